/* Makefile */
# verilator build and run of the uart receiver testbench
SRCS := $(shell cat uart_rx.f)
BIN  := obj_dir/Vtb_uart_rx

.PHONY: all run clean

all: run

$(BIN): uart_rx.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_rx \
	  -f uart_rx.f -o Vtb_uart_rx

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/rx_fifo.sv */
//****************************************
// synchronous fifo
// circular buffer for any packed payload
//****************************************

`timescale 1ns/1ps

module rx_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8              // power of two
) (
  input  logic     clk_rx,
  input  logic     rst_clk_rx,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,       // oldest entry, valid when not empty
  output logic     empty,
  output logic     full,
  output logic     drop        // push lost because full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t    mem [DEPTH];
  logic [AW:0] wr_ptr;  // msb is the wrap bit
  logic [AW:0] rd_ptr;
  logic        do_push;

  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_push = push && !full;
  assign drop    = push && full;
  assign head    = mem[rd_ptr[AW-1:0]];

  // storage, no reset needed
  always_ff @(posedge clk_rx)
  begin
    if (do_push)
      mem[wr_ptr[AW-1:0]] <= push_data;
  end

  // pointers
  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // the reader only pops what it has seen at the head
  a_no_pop_empty : assert property (@(posedge clk_rx) disable iff (rst_clk_rx)
    pop |-> !empty);

endmodule

/* hdl/uart_pkg.sv */
//****************************************
// uart framing package
// character record, frame indicator encoding
// and the frame timeout for the receiver
//****************************************

package uart_pkg;

  // one received character plus its framing flag
  typedef struct packed {
    logic [7:0] data;     // received byte, lsb first on the line
    logic       frm_err;  // stop bit sampled low
  } rx_char_t;

  // frame indicator, alternates per frame so a scope can separate them
  typedef enum logic [1:0] {
    FRAME_IDLE = 2'b00,
    FRAME_01   = 2'b01,
    FRAME_10   = 2'b10
  } frame_ind_t;

  //****************************************
  // framing constants
  //****************************************

  // oversample enables before the indicator gives up on a frame
  // a full frame is 160 enables, so this sits just under it
  localparam int unsigned FRAME_TIMEOUT = 156;

endpackage

/* hdl/uart_rx.sv */
//****************************************
// uart receiver top level
// front end, controller, fifo, bus slave
//****************************************

`timescale 1ns/1ps

module uart_rx #(
  parameter int CLOCK_RATE = 50_000_000,
  parameter int BAUD_RATE  = 115_200,
  parameter int FIFO_DEPTH = 8
) (
  input  logic            clk_rx,
  input  logic            rst_clk_rx,
  input  logic            rxd,
  input  wb_pkg::wb_req_t wb_req,
  output wb_pkg::wb_rsp_t wb_rsp
);

  import uart_pkg::*;

  logic       rxd_sync;
  logic       baud_x16_en;
  rx_char_t   char_out;
  logic       char_valid;
  frame_ind_t frame_ind;
  rx_char_t   head;
  logic       empty;
  logic       drop;
  logic       pop;

  uart_rx_front #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD_RATE  (BAUD_RATE)
  ) u_front (
    .clk_rx      (clk_rx),
    .rst_clk_rx  (rst_clk_rx),
    .rxd         (rxd),
    .rxd_sync    (rxd_sync),
    .baud_x16_en (baud_x16_en)
  );

  uart_rx_ctl u_ctl (
    .clk_rx      (clk_rx),
    .rst_clk_rx  (rst_clk_rx),
    .baud_x16_en (baud_x16_en),
    .rxd_sync    (rxd_sync),
    .char_out    (char_out),
    .char_valid  (char_valid),
    .frame_ind   (frame_ind)
  );

  rx_fifo #(
    .payload_t (rx_char_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_fifo (
    .clk_rx     (clk_rx),
    .rst_clk_rx (rst_clk_rx),
    .push       (char_valid),  // no back pressure toward the line
    .push_data  (char_out),
    .pop        (pop),
    .head       (head),
    .empty      (empty),
    .full       (),            // drop covers it for the slave
    .drop       (drop)
  );

  uart_rx_wb u_wb (
    .clk_rx       (clk_rx),
    .rst_clk_rx   (rst_clk_rx),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .head         (head),
    .empty        (empty),
    .drop         (drop),
    .pop          (pop),
    .char_valid   (char_valid),
    .char_frm_err (char_out.frm_err),
    .frame_ind    (frame_ind)
  );

endmodule

/* hdl/uart_rx_ctl.sv */
//****************************************
// uart receive controller
// start/data/stop fsm, framing check and
// the alternating frame indicator
//****************************************

`timescale 1ns/1ps

module uart_rx_ctl (
  input  logic                 clk_rx,
  input  logic                 rst_clk_rx,
  input  logic                 baud_x16_en,  // 16x oversample enable
  input  logic                 rxd_sync,     // synchronized serial line
  output uart_pkg::rx_char_t   char_out,     // valid with char_valid
  output logic                 char_valid,   // one clock per frame
  output uart_pkg::frame_ind_t frame_ind
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    START = 2'b01,
    DATA  = 2'b10,
    STOP  = 2'b11
  } state_t;

  state_t     state;
  logic [3:0] os_cnt;       // oversample count, 16 per bit
  logic [2:0] bit_cnt;      // data bit being received
  logic       os_done;      // at a sample point
  logic       stop_sample;  // enable on which the stop bit is looked at
  rx_char_t   char_q;       // assembled character

  frame_ind_t frame_last;   // last non idle value, for alternation
  logic [7:0] frame_cnt;    // countdown while a frame is open

  assign os_done     = (os_cnt == 4'd0);
  assign stop_sample = baud_x16_en && (state == STOP) && os_done;

  //****************************************
  // receive state machine
  //****************************************

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      state <= IDLE;
    end
    else if (baud_x16_en)
    begin
      case (state)
        IDLE:
        begin
          if (!rxd_sync)
            state <= START;  // possible start edge
        end
        START:
        begin
          if (os_done)
            state <= rxd_sync ? IDLE : DATA;  // high again at mid bit is a glitch
        end
        DATA:
        begin
          if (os_done && bit_cnt == 3'd7)
            state <= STOP;
        end
        STOP:
        begin
          if (os_done)
            state <= IDLE;  // half a bit early, leaves slack for clock mismatch
        end
        default: state <= IDLE;
      endcase
    end
  end

  // oversample counter
  // 7 reaches the middle of the start bit, 15 steps a whole bit
  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      os_cnt <= 4'd0;
    end
    else if (baud_x16_en)
    begin
      if (!os_done)
        os_cnt <= os_cnt - 1'b1;
      else if (state == IDLE && !rxd_sync)
        os_cnt <= 4'd7;
      else if ((state == START && !rxd_sync) || state == DATA)
        os_cnt <= 4'd15;
    end
  end

  // bit counter, cleared at start confirm
  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      bit_cnt <= 3'd0;
    end
    else if (baud_x16_en && os_done)
    begin
      if (state == START)
        bit_cnt <= 3'd0;
      else if (state == DATA)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // data capture and stop check
  always_ff @(posedge clk_rx)
  begin
    if (baud_x16_en && os_done && state == DATA)
      char_q.data[bit_cnt] <= rxd_sync;  // lsb first
    if (stop_sample)
      char_q.frm_err <= !rxd_sync;       // stop bit must be high
  end

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
      char_valid <= 1'b0;
    else
      char_valid <= stop_sample;  // flag and data go out together
  end

  assign char_out = char_q;

  //****************************************
  // frame indicator
  //****************************************

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      frame_ind  <= FRAME_IDLE;
      frame_last <= FRAME_10;  // so the first frame shows 01
    end
    else if (baud_x16_en)
    begin
      if (frame_ind == FRAME_IDLE && state == IDLE && !rxd_sync)
      begin
        frame_ind  <= (frame_last == FRAME_01) ? FRAME_10 : FRAME_01;
        frame_last <= (frame_last == FRAME_01) ? FRAME_10 : FRAME_01;
      end
      else if (frame_ind != FRAME_IDLE && frame_cnt == 8'd10 && state == IDLE)
      begin
        frame_ind <= FRAME_IDLE;  // fsm dropped out early, glitch
      end
      else if (frame_ind != FRAME_IDLE && frame_cnt == 8'd0)
      begin
        frame_ind <= FRAME_IDLE;  // timed out
      end
    end
  end

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
      frame_cnt <= 8'(FRAME_TIMEOUT);
    else if (baud_x16_en)
    begin
      if (frame_ind == FRAME_IDLE)
        frame_cnt <= 8'(FRAME_TIMEOUT);  // rearm while idle
      else if (frame_cnt != 8'd0)
        frame_cnt <= frame_cnt - 8'd1;
    end
  end

  //****************************************
  // checks
  //****************************************

  a_valid_pulse : assert property (@(posedge clk_rx) disable iff (rst_clk_rx)
    char_valid |=> !char_valid);

  // valid only right after the fsm has left stop
  a_valid_after_stop : assert property (@(posedge clk_rx) disable iff (rst_clk_rx)
    char_valid |-> (state == IDLE) && ($past(state) == STOP));

endmodule

/* hdl/uart_rx_front.sv */
//****************************************
// uart receive front end
// rxd synchronizer and 16x baud enable
//****************************************

`timescale 1ns/1ps

module uart_rx_front #(
  parameter int CLOCK_RATE = 50_000_000,
  parameter int BAUD_RATE  = 115_200
) (
  input  logic clk_rx,
  input  logic rst_clk_rx,
  input  logic rxd,          // raw pin, asynchronous
  output logic rxd_sync,     // rxd after two flops
  output logic baud_x16_en   // one cycle pulse at 16x baud
);

  localparam int DIVISOR = CLOCK_RATE / (16 * BAUD_RATE);
  localparam int CNT_W   = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

  logic             rxd_meta;  // first stage, may go metastable
  logic [CNT_W-1:0] div_cnt;   // counts down to the next enable

  // two stage synchronizer, idle line is high
  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end
    else
    begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  // baud divider, enable registered so it is glitch free
  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      div_cnt     <= CNT_W'(DIVISOR - 1);
      baud_x16_en <= 1'b0;
    end
    else
    begin
      baud_x16_en <= (div_cnt == '0);
      if (div_cnt == '0)
        div_cnt <= CNT_W'(DIVISOR - 1);  // reload
      else
        div_cnt <= div_cnt - 1'b1;
    end
  end

  // enable is a single pulse whenever the divisor leaves room for a gap
  a_en_single : assert property (@(posedge clk_rx) disable iff (rst_clk_rx)
    (DIVISOR > 1 && baud_x16_en) |=> !baud_x16_en);

endmodule

/* hdl/uart_rx_wb.sv */
//****************************************
// wishbone classic slave for the receiver
// data/status/error count registers
//****************************************

`timescale 1ns/1ps

module uart_rx_wb (
  input  logic                 clk_rx,
  input  logic                 rst_clk_rx,
  input  wb_pkg::wb_req_t      wb_req,
  output wb_pkg::wb_rsp_t      wb_rsp,
  input  uart_pkg::rx_char_t   head,          // fifo head
  input  logic                 empty,
  input  logic                 drop,          // fifo lost a character
  output logic                 pop,
  input  logic                 char_valid,    // straight from the controller
  input  logic                 char_frm_err,
  input  uart_pkg::frame_ind_t frame_ind
);

  import uart_pkg::*;
  import wb_pkg::*;

  logic       req_new;   // request not yet acked
  logic       ack_q;
  logic [7:0] dat_q;
  logic [7:0] rd_dat;
  logic [7:0] status;
  logic       overflow;  // sticky
  logic [7:0] err_cnt;   // saturating
  logic       clr;       // status write

  assign req_new = wb_req.cyc && wb_req.stb && !ack_q;
  assign clr     = req_new && wb_req.we && (wb_req.adr == REG_STATUS);

  assign status = {2'b00,
                   head.frm_err & ~empty,       // bit 5
                   frame_ind,                   // bits 4:3
                   (frame_ind != FRAME_IDLE),   // busy
                   overflow,
                   ~empty};

  // read mux
  always_comb
  begin
    case (wb_req.adr)
      REG_DATA:   rd_dat = empty ? 8'h00 : head.data;
      REG_STATUS: rd_dat = status;
      REG_ERRCNT: rd_dat = err_cnt;
      default:    rd_dat = 8'h00;
    endcase
  end

  //****************************************
  // bus handshake
  //****************************************

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      ack_q <= 1'b0;
      pop   <= 1'b0;
    end
    else
    begin
      ack_q <= req_new;  // one cycle, then dropped
      // pop decided when the head is sampled, lands on the ack cycle
      pop   <= req_new && !wb_req.we && (wb_req.adr == REG_DATA) && !empty;
    end
  end

  always_ff @(posedge clk_rx)
  begin
    if (req_new)
      dat_q <= wb_req.we ? 8'h00 : rd_dat;
  end

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

  //****************************************
  // error flags
  //****************************************

  always_ff @(posedge clk_rx)
  begin
    if (rst_clk_rx)
    begin
      overflow <= 1'b0;
      err_cnt  <= 8'd0;
    end
    else
    begin
      if (drop)
        overflow <= 1'b1;  // a new loss wins over a clear
      else if (clr)
        overflow <= 1'b0;

      if (clr)
        err_cnt <= 8'd0;
      else if (char_valid && char_frm_err && err_cnt != 8'hff)
        err_cnt <= err_cnt + 8'd1;  // counts dropped ones too
    end
  end

  a_ack_in_cycle : assert property (@(posedge clk_rx) disable iff (rst_clk_rx)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

endmodule

/* hdl/wb_pkg.sv */
//****************************************
// wishbone bus package
// classic request/response records and
// the receiver register map
//****************************************

package wb_pkg;

  // master to slave
  typedef struct packed {
    logic       cyc;  // bus cycle in progress
    logic       stb;  // transfer strobe
    logic       we;   // write enable
    logic [1:0] adr;  // register index
    logic [7:0] dat;  // write data
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic       ack;  // one cycle per transfer
    logic [7:0] dat;  // read data, valid with ack
  } wb_rsp_t;

  // register map
  localparam logic [1:0] REG_DATA   = 2'd0;  // head byte, read pops
  localparam logic [1:0] REG_STATUS = 2'd1;  // flags, write clears
  localparam logic [1:0] REG_ERRCNT = 2'd2;  // framing error count

endpackage

/* sim/tb_uart_rx.sv */
//****************************************
// uart receiver testbench
// serial driver, wishbone master and a
// stimulus table checked against a fifo model
//****************************************

`timescale 1ns/1ps

module tb_uart_rx;

  import uart_pkg::*;
  import wb_pkg::*;

  localparam int CLOCK_RATE  = 16_000_000;
  localparam int BAUD_RATE   = 500_000;
  localparam int FIFO_DEPTH  = 4;
  localparam int BIT_CYCLES  = CLOCK_RATE / BAUD_RATE;  // 32 clocks per bit
  localparam int GAP_CYCLES  = 2 * BIT_CYCLES;          // idle line between frames
  localparam int ROWS        = 12;
  localparam int CYCLE_LIMIT = (ROWS + 6) * 400;
  localparam int ACK_LIMIT   = 16;                      // classic ack is due after one cycle

  // one line of the stimulus table
  typedef struct packed {
    logic [7:0] data;
    logic       stop;      // stop bit level on the line
    logic       glitch;    // short low pulse instead of a frame
    logic       read_now;  // read the character back right after it
  } stim_row_t;

  logic        clk_rx;
  logic        rst_clk_rx;
  logic        rxd;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;

  stim_row_t   stim [ROWS];
  rx_char_t    exp_q [$];   // model of the fifo contents
  frame_ind_t  exp_ind;     // indicator value of the current frame
  logic        exp_ovf;     // sticky overflow expected
  int          exp_err;     // frames sent with a low stop bit
  int          errors;
  int          checks;
  int          cycles = 0;
  int unsigned seed_val;
  logic [7:0]  rd;

  uart_rx #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD_RATE  (BAUD_RATE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk_rx     (clk_rx),
    .rst_clk_rx (rst_clk_rx),
    .rxd        (rxd),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp)
  );

  initial clk_rx = 1'b0;
  always #5 clk_rx = ~clk_rx;  // 100 MHz sim clock, rate set by parameters

  // run limit
  always @(posedge clk_rx)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //****************************************
  // helpers
  //****************************************

  task automatic compare(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
    checks++;
    if (expected !== actual)
    begin
      errors++;
      $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
    end
  endtask

  // one classic cycle, request held until ack
  task automatic wb_transfer(input logic we, input logic [1:0] adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk_rx);
    #1;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(posedge clk_rx);
    #1;
    while (!wb_rsp.ack && waited < ACK_LIMIT)
    begin
      @(posedge clk_rx);
      #1;
      waited++;
    end
    if (!wb_rsp.ack)
    begin
      errors++;
      $display("bus slave gave no ack for register %0d within %0d cycles", adr, ACK_LIMIT);
    end
    rdat = wb_rsp.dat;  // valid with ack
    @(posedge clk_rx);  // request stays up until the edge that samples ack
    #1;
    wb_req = '0;
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [7:0] rdat);
    wb_transfer(1'b0, adr, 8'h00, rdat);
  endtask

  task automatic write_reg(input logic [1:0] adr, input logic [7:0] wdat);
    logic [7:0] ignored;
    wb_transfer(1'b1, adr, wdat, ignored);
  endtask

  // hold the line for a number of clocks, ends 1 ns after an edge
  task automatic drive_bit(input logic value, input int n);
    rxd = value;
    repeat (n) @(posedge clk_rx);
    #1;
  endtask

  task automatic send_char(input logic [7:0] data, input logic stop);
    drive_bit(1'b0, BIT_CYCLES);  // start
    for (int i = 0; i < 8; i++)
      drive_bit(data[i], BIT_CYCLES);  // lsb first
    drive_bit(stop, BIT_CYCLES);
    rxd = 1'b1;
  endtask

  // low for less than a quarter bit
  task automatic send_glitch();
    drive_bit(1'b0, 6);
    rxd = 1'b1;
  endtask

  // status polled a few bits into a frame
  task automatic poll_busy();
    logic [7:0] st;
    repeat (100) @(posedge clk_rx);
    read_reg(REG_STATUS, st);
    compare("busy during frame", 8'd1, 8'(st[2]));
    compare("frame indicator during frame", 8'(exp_ind), 8'(st[4:3]));
  endtask

  // status with no frame on the line
  task automatic check_quiet_status(input string name);
    logic [7:0] st;
    read_reg(REG_STATUS, st);
    compare({name, " not empty"}, 8'(exp_q.size() != 0), 8'(st[0]));
    compare({name, " overflow"}, 8'(exp_ovf), 8'(st[1]));
    compare({name, " busy"}, 8'd0, 8'(st[2]));
    compare({name, " frame indicator"}, 8'(FRAME_IDLE), 8'(st[4:3]));
  endtask

  // head flags from status, then the byte, model pops alongside
  task automatic read_head();
    logic [7:0] st;
    logic [7:0] dat;
    read_reg(REG_STATUS, st);
    compare("head present", 8'd1, 8'(st[0]));
    compare("head frm_err", 8'(exp_q[0].frm_err), 8'(st[5]));
    read_reg(REG_DATA, dat);
    compare("head data", exp_q[0].data, dat);
    void'(exp_q.pop_front());
  endtask

  //****************************************
  // stimulus
  //****************************************

  initial
  begin
    rst_clk_rx = 1'b1;
    rxd        = 1'b1;  // idle line
    wb_req     = '0;
    errors     = 0;
    checks     = 0;
    exp_ind    = FRAME_IDLE;
    exp_ovf    = 1'b0;
    exp_err    = 0;
    seed_val   = $urandom(32'hb75d4bbe);

    // good frames, then low stop bits, a glitch, then an overrun burst
    stim[0] = '{data: 8'h55, stop: 1'b1, glitch: 1'b0, read_now: 1'b1};
    stim[1] = '{data: 8'ha3, stop: 1'b1, glitch: 1'b0, read_now: 1'b1};
    stim[2] = '{data: 8'h01, stop: 1'b1, glitch: 1'b0, read_now: 1'b1};
    stim[3] = '{data: 8'h3c, stop: 1'b0, glitch: 1'b0, read_now: 1'b1};
    stim[4] = '{data: 8'hfe, stop: 1'b0, glitch: 1'b0, read_now: 1'b1};
    stim[5] = '{data: 8'h00, stop: 1'b1, glitch: 1'b1, read_now: 1'b0};
    for (int i = 6; i < ROWS; i++)
      stim[i] = '{data: 8'($urandom()), stop: 1'b1, glitch: 1'b0, read_now: 1'b0};
    stim[ROWS-1].stop = 1'b0;  // dropped and still counted as an error

    repeat (8) @(posedge clk_rx);
    #1;
    rst_clk_rx = 1'b0;

    foreach (stim[r])
    begin
      // every row opens a frame, the first one after reset shows 01
      exp_ind = (r % 2 == 0) ? FRAME_01 : FRAME_10;
      if (stim[r].glitch)
      begin
        send_glitch();
        repeat (400) @(posedge clk_rx);  // longer than one frame
        check_quiet_status("after glitch");
      end
      else
      begin
        fork
          send_char(stim[r].data, stim[r].stop);
          poll_busy();
        join
        if (exp_q.size() < FIFO_DEPTH)
          exp_q.push_back(rx_char_t'{data: stim[r].data, frm_err: !stim[r].stop});
        else
          exp_ovf = 1'b1;  // lost, fifo was full
        if (!stim[r].stop)
          exp_err++;
        drive_bit(1'b1, GAP_CYCLES);
        check_quiet_status("after frame");
        if (stim[r].read_now)
        begin
          read_head();
          read_reg(REG_ERRCNT, rd);
          compare("error count", 8'(exp_err), rd);
        end
      end
    end

    //****************************************
    // overrun drain and clear
    //****************************************
    read_reg(REG_STATUS, rd);
    compare("overflow set by burst", 8'd1, 8'(rd[1]));
    while (exp_q.size() != 0)
      read_head();
    read_reg(REG_DATA, rd);
    compare("data read while empty", 8'h00, rd);
    check_quiet_status("after drain");
    read_reg(REG_ERRCNT, rd);
    compare("error count before clear", 8'(exp_err), rd);

    write_reg(REG_STATUS, 8'h00);  // clears overflow and count
    exp_ovf = 1'b0;
    read_reg(REG_STATUS, rd);
    compare("overflow after clear", 8'd0, 8'(rd[1]));
    read_reg(REG_ERRCNT, rd);
    compare("error count after clear", 8'd0, rd);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* uart_rx.f */
hdl/uart_pkg.sv
hdl/wb_pkg.sv
hdl/uart_rx_front.sv
hdl/uart_rx_ctl.sv
hdl/rx_fifo.sv
hdl/uart_rx_wb.sv
hdl/uart_rx.sv
sim/tb_uart_rx.sv
